// ==== exe_top.f ====
+incdir+verilog
verilog/exe_data_pkg.sv
verilog/exe_op_pkg.sv
verilog/exe_stage_ctrl.sv
verilog/int_csr_unit.sv
verilog/trap_unit.sv
verilog/mcsr_file.sv
verilog/exe_top.sv
sim/exe_top_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f exe_top.f --top-module exe_top_tb -o exe_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/exe_top_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sim/exe_top_tb.sv ====
/* Execute stage testbench */
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_top_tb import exe_data_pkg::*, exe_op_pkg::*; ();

  // one table row with stimulus and expected result
  typedef struct packed {
    op_e        op;
    xlen_t      pc;
    inst_t      inst;
    xlen_t      op1;
    xlen_t      op2;
    xlen_t      op3;
    ridx_t      rd;
    logic       rd_wen;
    logic       skip;
    logic       ovf;
    logic [7:0] stall;
    logic       e_rd_wen;
    xlen_t      e_rd_wdata;
    logic       e_jmp;
    xlen_t      e_jmp_addr;
    intr_no_t   e_intr;
    logic       e_skip;
  } entry_t;

  logic     clk;
  logic     rst;
  logic     i_valid;
  logic     o_ready;
  op_e      i_op;
  xlen_t    i_pc;
  inst_t    i_inst;
  xlen_t    i_op1;
  xlen_t    i_op2;
  xlen_t    i_op3;
  ridx_t    i_rd;
  logic     i_rd_wen;
  logic     i_skip_cmt;
  logic     i_mtime_overflow;
  logic     o_valid;
  logic     i_ready;
  xlen_t    o_pc;
  inst_t    o_inst;
  ridx_t    o_rd;
  logic     o_rd_wen;
  xlen_t    o_rd_wdata;
  logic     o_jmp;
  xlen_t    o_jmp_addr;
  intr_no_t o_intr_no;
  logic     o_skip_cmt;

  entry_t   entries[$];
  entry_t   cur;
  int       cur_idx;
  integer   seed;

  // shadow machine CSRs
  xlen_t    sh_mstatus;
  xlen_t    sh_mie;
  xlen_t    sh_mtvec;
  xlen_t    sh_mepc;
  xlen_t    sh_mcause;
  xlen_t    sh_mip;

  exe_top dut_i (
    .clk              (clk),
    .rst              (rst),
    .i_valid          (i_valid),
    .o_ready          (o_ready),
    .i_op             (i_op),
    .i_pc             (i_pc),
    .i_inst           (i_inst),
    .i_op1            (i_op1),
    .i_op2            (i_op2),
    .i_op3            (i_op3),
    .i_rd             (i_rd),
    .i_rd_wen         (i_rd_wen),
    .i_skip_cmt       (i_skip_cmt),
    .i_mtime_overflow (i_mtime_overflow),
    .o_valid          (o_valid),
    .i_ready          (i_ready),
    .o_pc             (o_pc),
    .o_inst           (o_inst),
    .o_rd             (o_rd),
    .o_rd_wen         (o_rd_wen),
    .o_rd_wdata       (o_rd_wdata),
    .o_jmp            (o_jmp),
    .o_jmp_addr       (o_jmp_addr),
    .o_intr_no        (o_intr_no),
    .o_skip_cmt       (o_skip_cmt)
  );

  always #5 clk = ~clk;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s entry %0d: got %h expected %h",
                              name, cur_idx, got, exp));
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s entry %0d: got %h expected %h",
                              name, cur_idx, got, exp));
    end
  endtask

  task automatic check_ridx(input string name, input ridx_t got, input ridx_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s entry %0d: got %h expected %h",
                              name, cur_idx, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s entry %0d: got %h expected %h",
                              name, cur_idx, got, exp));
    end
  endtask

  task automatic check_intr(input string name, input intr_no_t got, input intr_no_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s entry %0d: got %h expected %h",
                              name, cur_idx, got, exp));
    end
  endtask

  function automatic xlen_t csr_read(input csr_addr_t a);
    case (a)
      `CSR_MSTATUS: return sh_mstatus;
      `CSR_MIE:     return sh_mie;
      `CSR_MTVEC:   return sh_mtvec;
      `CSR_MEPC:    return sh_mepc;
      `CSR_MCAUSE:  return sh_mcause;
      `CSR_MIP:     return sh_mip;
      default:      return '0;
    endcase
  endfunction

  function automatic void csr_write(input csr_addr_t a, input xlen_t v);
    case (a)
      `CSR_MSTATUS: sh_mstatus = v;
      `CSR_MIE:     sh_mie = v;
      `CSR_MTVEC:   sh_mtvec = v;
      `CSR_MEPC:    sh_mepc = v;
      `CSR_MCAUSE:  sh_mcause = v;
      `CSR_MIP:     sh_mip = v;
      default: ;
    endcase
  endfunction

  // reference model updating the shadow CSRs in program order
  function automatic entry_t predict(input entry_t e);
    logic      irq;
    csr_addr_t a;
    xlen_t     old;
    irq = sh_mstatus[3] && sh_mie[7] && e.ovf;
    a = e.inst[31:20];
    e.e_rd_wen = 1'b0;
    e.e_rd_wdata = '0;
    e.e_jmp = 1'b0;
    e.e_jmp_addr = '0;
    e.e_intr = '0;
    e.e_skip = e.skip;
    if (irq || e.op == op_ecall) begin
      e.e_jmp = 1'b1;
      e.e_jmp_addr = sh_mtvec;
      e.e_skip = 1'b1;
      sh_mepc = e.pc;
      sh_mcause = irq ? `CAUSE_MTIMER : `CAUSE_ECALL_M;
      sh_mstatus[7] = sh_mstatus[3];
      sh_mstatus[3] = 1'b0;
      if (irq) begin
        sh_mip = `MIP_MTIP;
        e.e_intr = `INTR_NO_TIMER;
      end
    end else if (e.op == op_mret) begin
      e.e_jmp = 1'b1;
      e.e_jmp_addr = sh_mepc;
      e.e_skip = 1'b1;
      sh_mstatus[3] = sh_mstatus[7];
    end else begin
      e.e_rd_wen = e.rd_wen && (e.op != op_beq) && (e.op != op_bne);
      case (e.op)
        op_add: e.e_rd_wdata = e.op1 + e.op2;
        op_sub: e.e_rd_wdata = e.op1 - e.op2;
        op_and: e.e_rd_wdata = e.op1 & e.op2;
        op_or:  e.e_rd_wdata = e.op1 | e.op2;
        op_xor: e.e_rd_wdata = e.op1 ^ e.op2;
        op_sll: e.e_rd_wdata = e.op1 << e.op2[5:0];
        op_srl: e.e_rd_wdata = e.op1 >> e.op2[5:0];
        op_slt: e.e_rd_wdata = {63'b0, ($signed(e.op1) < $signed(e.op2))};
        op_beq: begin
          e.e_jmp = (e.op1 == e.op2);
          e.e_jmp_addr = e.pc + e.op3;
        end
        op_bne: begin
          e.e_jmp = (e.op1 != e.op2);
          e.e_jmp_addr = e.pc + e.op3;
        end
        op_jalr: begin
          e.e_rd_wdata = e.pc + 64'd4;
          e.e_jmp = 1'b1;
          e.e_jmp_addr = (e.op1 + e.op2) & ~64'd1;
        end
        op_csrrw: begin
          old = csr_read(a);
          e.e_rd_wdata = old;
          csr_write(a, e.op1);
        end
        op_csrrs: begin
          old = csr_read(a);
          e.e_rd_wdata = old;
          csr_write(a, old | e.op1);
        end
        default: e.e_rd_wdata = '0;
      endcase
    end
    return e;
  endfunction

  task automatic add_entry(input op_e op, input xlen_t pc, input xlen_t op1,
                           input xlen_t op2, input xlen_t op3, input csr_addr_t csr,
                           input logic ovf, input logic [7:0] stall);
    entry_t e;
    e = '0;
    e.op = op;
    e.pc = pc;
    e.inst = {csr, 20'h00073};
    e.op1 = op1;
    e.op2 = op2;
    e.op3 = op3;
    e.rd = ridx_t'(entries.size() % 31 + 1);
    e.rd_wen = 1'b1;
    e.skip = (entries.size() % 4 == 3);
    e.ovf = ovf;
    e.stall = stall;
    entries.push_back(e);
  endtask

  task automatic add_random_ops(input int count);
    entry_t e;
    integer r;
    repeat (count) begin
      e = '0;
      r = $random(seed);
      e.op = op_e'({5'b0, r[2:0]});
      e.pc = {48'h0, r[31:18], 2'b00};
      e.inst = {12'h0, 20'h00033};
      e.op1 = {$random(seed), $random(seed)};
      e.op2 = {$random(seed), $random(seed)};
      e.rd = r[13:9];
      e.rd_wen = r[6];
      e.skip = r[7];
      e.ovf = r[8];
      e.stall = r[4] ? 8'd2 : 8'd0;
      entries.push_back(e);
    end
  endtask

  task automatic verify_result(input entry_t e);
    check_bit("o_valid", o_valid, 1'b1);
    check_xlen("o_pc", o_pc, e.pc);
    check_inst("o_inst", o_inst, e.inst);
    check_ridx("o_rd", o_rd, e.rd);
    check_bit("o_rd_wen", o_rd_wen, e.e_rd_wen);
    if (e.e_rd_wen) check_xlen("o_rd_wdata", o_rd_wdata, e.e_rd_wdata);
    check_bit("o_jmp", o_jmp, e.e_jmp);
    if (e.e_jmp) check_xlen("o_jmp_addr", o_jmp_addr, e.e_jmp_addr);
    check_intr("o_intr_no", o_intr_no, e.e_intr);
    check_bit("o_skip_cmt", o_skip_cmt, e.e_skip);
  endtask

  // called 1 ns after a rising edge
  task automatic run_entry(input entry_t e);
    int n;
    n = 0;
    while (!o_ready) begin
      n++;
      if (n > 100) stop_on_error("timeout waiting for o_ready");
      @(posedge clk);
      #1;
    end
    i_valid = 1'b1;
    i_op = e.op;
    i_pc = e.pc;
    i_inst = e.inst;
    i_op1 = e.op1;
    i_op2 = e.op2;
    i_op3 = e.op3;
    i_rd = e.rd;
    i_rd_wen = e.rd_wen;
    i_skip_cmt = e.skip;
    i_mtime_overflow = e.ovf;
    i_ready = (e.stall == 8'd0);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    i_mtime_overflow = 1'b0;
    n = 0;
    while (!o_valid) begin
      n++;
      if (n > 100) stop_on_error("timeout waiting for o_valid");
      @(posedge clk);
      #1;
    end
    verify_result(e);
    check_bit("o_ready", o_ready, 1'b0);
    // result must hold under back-pressure
    repeat (e.stall) begin
      @(posedge clk);
      #1;
      verify_result(e);
      check_bit("o_ready", o_ready, 1'b0);
    end
    i_ready = 1'b1;
    @(posedge clk);
    #1;
    check_bit("o_valid", o_valid, 1'b0);
    check_bit("o_ready", o_ready, 1'b1);
    check_xlen("o_pc", o_pc, '0);
    check_inst("o_inst", o_inst, '0);
    check_bit("o_jmp", o_jmp, 1'b0);
  endtask

  task automatic build_table();
    // ALU ops and signed slt
    add_entry(op_add, 64'h100, 64'h0000_0001_ffff_ffff, 64'h1, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_sub, 64'h104, 64'h5, 64'h7, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_and, 64'h108, 64'hff00_ff00_1234_5678, 64'h0f0f_0f0f_ffff_0000,
              64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_or, 64'h10c, 64'h00f0, 64'h0f00, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_xor, 64'h110, 64'haaaa_5555_aaaa_5555, 64'hffff_ffff_0000_0000,
              64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_sll, 64'h114, 64'h1, 64'h44, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_srl, 64'h118, 64'h8000_0000_0000_0000, 64'h7f, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_slt, 64'h11c, 64'hffff_ffff_ffff_fffb, 64'h3, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_slt, 64'h120, 64'h3, 64'hffff_ffff_ffff_fffb, 64'h0, 12'h0, 1'b0, 8'd0);
    // branches and jalr
    add_entry(op_beq, 64'h200, 64'h42, 64'h42, 64'h40, 12'h0, 1'b0, 8'd0);
    add_entry(op_beq, 64'h204, 64'h42, 64'h43, 64'h40, 12'h0, 1'b0, 8'd0);
    add_entry(op_bne, 64'h208, 64'h1, 64'h2, 64'hffff_ffff_ffff_fff0, 12'h0, 1'b0, 8'd0);
    add_entry(op_bne, 64'h20c, 64'h7, 64'h7, 64'h10, 12'h0, 1'b0, 8'd0);
    add_entry(op_jalr, 64'h210, 64'h1000, 64'h35, 64'h0, 12'h0, 1'b0, 8'd0);
    // CSR read-modify-write
    add_entry(op_csrrw, 64'h300, 64'h8000_1000, 64'h0, 64'h0, `CSR_MTVEC, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h304, 64'h0, 64'h0, 64'h0, `CSR_MTVEC, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h308, 64'h88, 64'h0, 64'h0, `CSR_MSTATUS, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h30c, 64'h0, 64'h0, 64'h0, `CSR_MSTATUS, 1'b0, 8'd0);
    add_entry(op_csrrw, 64'h310, 64'h0, 64'h0, 64'h0, `CSR_MSTATUS, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h314, 64'h1, 64'h0, 64'h0, 12'h7c0, 1'b0, 8'd0);
    // ecall and an mret back to the ecall pc
    add_entry(op_ecall, 64'h1000, 64'h0, 64'h0, 64'h0, 12'h0, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h1004, 64'h0, 64'h0, 64'h0, `CSR_MCAUSE, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h1008, 64'h0, 64'h0, 64'h0, `CSR_MEPC, 1'b0, 8'd0);
    add_entry(op_mret, 64'h100c, 64'h0, 64'h0, 64'h0, 12'h0, 1'b0, 8'd0);
    // timer interrupt and the same instruction with MIE clear
    add_entry(op_csrrs, 64'h1010, 64'h8, 64'h0, 64'h0, `CSR_MSTATUS, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h1014, 64'h80, 64'h0, 64'h0, `CSR_MIE, 1'b0, 8'd0);
    add_entry(op_add, 64'h2000, 64'h11, 64'h22, 64'h0, 12'h0, 1'b1, 8'd0);
    add_entry(op_csrrs, 64'h8000_1000, 64'h0, 64'h0, 64'h0, `CSR_MCAUSE, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h8000_1004, 64'h0, 64'h0, 64'h0, `CSR_MIP, 1'b0, 8'd0);
    add_entry(op_csrrs, 64'h8000_1008, 64'h0, 64'h0, 64'h0, `CSR_MSTATUS, 1'b0, 8'd0);
    add_entry(op_add, 64'h2000, 64'h11, 64'h22, 64'h0, 12'h0, 1'b1, 8'd0);
    // back-pressure
    add_entry(op_add, 64'h3000, 64'h123, 64'h456, 64'h0, 12'h0, 1'b0, 8'd4);
    add_entry(op_csrrw, 64'h3004, 64'h3000, 64'h0, 64'h0, `CSR_MTVEC, 1'b0, 8'd3);
    add_entry(op_csrrs, 64'h3008, 64'h0, 64'h0, 64'h0, `CSR_MTVEC, 1'b0, 8'd1);
    add_entry(op_ecall, 64'h4000, 64'h0, 64'h0, 64'h0, 12'h0, 1'b0, 8'd2);
    add_entry(op_csrrs, 64'h3000, 64'h0, 64'h0, 64'h0, `CSR_MEPC, 1'b0, 8'd0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    i_valid = 1'b0;
    i_op = op_nop;
    i_pc = '0;
    i_inst = '0;
    i_op1 = '0;
    i_op2 = '0;
    i_op3 = '0;
    i_rd = '0;
    i_rd_wen = 1'b0;
    i_skip_cmt = 1'b0;
    i_mtime_overflow = 1'b0;
    i_ready = 1'b1;
    cur_idx = -1;
    seed = 32'ha77f3a40;
    sh_mstatus = '0;
    sh_mie = '0;
    sh_mtvec = '0;
    sh_mepc = '0;
    sh_mcause = '0;
    sh_mip = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_bit("o_valid", o_valid, 1'b0);
    check_bit("o_ready", o_ready, 1'b1);
    build_table();
    add_random_ops(30);
    for (int i = 0; i < entries.size(); i++) begin
      cur_idx = i;
      cur = predict(entries[i]);
      run_entry(cur);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== verilog/exe_data_pkg.sv ====
/* Execute stage data types */
package exe_data_pkg;

  // register data and addresses
  typedef logic [63:0] xlen_t;

  // raw instruction, CSR address in bits 31:20
  typedef logic [31:0] inst_t;

  // destination register index
  typedef logic [4:0] ridx_t;

  typedef logic [11:0] csr_addr_t;

  // interrupt number reported with the result
  typedef logic [31:0] intr_no_t;

endpackage

// ==== verilog/exe_defines.svh ====
/* Execute stage CSR and trap constants */
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// machine CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MIP       12'h344

// mcause values, top bit marks an interrupt
`define CAUSE_ECALL_M 64'd11
`define CAUSE_MTIMER  64'h8000_0000_0000_0007

`define MIP_MTIP      64'h80
`define INTR_NO_TIMER 32'd7

`endif

// ==== verilog/exe_op_pkg.sv ====
/* Execute stage operations and states */
package exe_op_pkg;

  typedef enum logic [7:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_beq,
    op_bne,
    op_jalr,
    op_csrrw,
    op_csrrs,
    op_ecall,
    op_mret,
    op_nop
  } op_e;

  typedef enum logic [1:0] {st_idle, st_int, st_trap, st_done} ctrl_state_e;

  typedef enum logic [1:0] {tr_idle, tr_save, tr_cause, tr_done} trap_state_e;

endpackage

// ==== verilog/exe_stage_ctrl.sv ====
/* Execute stage control */
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_stage_ctrl import exe_data_pkg::*, exe_op_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_valid,
  input  op_e      i_op,
  input  xlen_t    i_pc,
  input  inst_t    i_inst,
  input  xlen_t    i_op1,
  input  xlen_t    i_op2,
  input  xlen_t    i_op3,
  input  ridx_t    i_rd,
  input  logic     i_rd_wen,
  input  logic     i_skip_cmt,
  input  logic     i_ready,
  input  logic     i_mtime_overflow,
  input  logic     i_irq_enabled,
  input  xlen_t    i_alu_rd_wdata,
  input  logic     i_alu_jmp,
  input  xlen_t    i_alu_jmp_addr,
  input  logic     i_trap_done,
  input  xlen_t    i_trap_jmp_addr,
  output logic     o_ready,
  output logic     o_valid,
  output xlen_t    o_pc,
  output inst_t    o_inst,
  output ridx_t    o_rd,
  output logic     o_rd_wen,
  output xlen_t    o_rd_wdata,
  output logic     o_jmp,
  output xlen_t    o_jmp_addr,
  output intr_no_t o_intr_no,
  output logic     o_skip_cmt,
  output logic     o_alu_start,
  output logic     o_trap_start,
  output op_e      o_trap_kind,
  output logic     o_commit,
  output op_e      o_held_op,
  output xlen_t    o_held_pc,
  output inst_t    o_held_inst,
  output xlen_t    o_held_op1,
  output xlen_t    o_held_op2,
  output xlen_t    o_held_op3
);

  ctrl_state_e state;
  logic        accept;
  logic        irq_take;
  logic        is_trap_op;
  logic        is_branch;
  ridx_t       rd_q;
  logic        rd_wen_q;
  logic        skip_q;
  logic        trap_q;
  logic        irq_q;

  assign accept     = i_valid && o_ready;
  assign irq_take   = i_irq_enabled && i_mtime_overflow;
  assign is_trap_op = (i_op == op_ecall) || (i_op == op_mret);
  assign is_branch  = (o_held_op == op_beq) || (o_held_op == op_bne);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      trap_q       <= 1'b0;
      irq_q        <= 1'b0;
      o_trap_start <= 1'b0;
      o_trap_kind  <= op_nop;
    end else begin
      o_trap_start <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            trap_q <= irq_take || is_trap_op;
            irq_q  <= irq_take;
            // interrupt wins over the instruction, which is dropped
            if (irq_take || is_trap_op) begin
              state        <= st_trap;
              o_trap_start <= 1'b1;
              o_trap_kind  <= irq_take ? op_nop : i_op;
            end else begin
              state <= st_int;
            end
          end
        end
        st_int:  state <= st_done;
        st_trap: if (i_trap_done) state <= st_done;
        st_done: if (i_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // held instruction
  always_ff @(posedge clk) begin
    if (accept) begin
      o_held_op   <= i_op;
      o_held_pc   <= i_pc;
      o_held_inst <= i_inst;
      o_held_op1  <= i_op1;
      o_held_op2  <= i_op2;
      o_held_op3  <= i_op3;
      rd_q        <= i_rd;
      rd_wen_q    <= i_rd_wen;
      skip_q      <= i_skip_cmt;
    end
  end

  assign o_ready     = (state == st_idle);
  assign o_valid     = (state == st_done);
  assign o_alu_start = (state == st_int);
  assign o_commit    = o_valid && i_ready && !trap_q;

  // result fields, all zero while not valid
  assign o_pc       = o_valid ? o_held_pc : '0;
  assign o_inst     = o_valid ? o_held_inst : '0;
  assign o_rd       = o_valid ? rd_q : '0;
  assign o_rd_wen   = o_valid && !trap_q && rd_wen_q && !is_branch;
  assign o_rd_wdata = (o_valid && !trap_q) ? i_alu_rd_wdata : '0;
  assign o_jmp      = o_valid && (trap_q || i_alu_jmp);
  assign o_skip_cmt = o_valid && (skip_q || trap_q);
  assign o_intr_no  = (o_valid && irq_q) ? `INTR_NO_TIMER : '0;

  always_comb begin
    o_jmp_addr = '0;
    if (o_valid) begin
      o_jmp_addr = trap_q ? i_trap_jmp_addr : i_alu_jmp_addr;
    end
  end

endmodule

// ==== verilog/exe_top.sv ====
/* Execute stage top */
`timescale 1ns/1ps

module exe_top import exe_data_pkg::*, exe_op_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_valid,
  output logic     o_ready,
  input  op_e      i_op,
  input  xlen_t    i_pc,
  input  inst_t    i_inst,
  input  xlen_t    i_op1,
  input  xlen_t    i_op2,
  input  xlen_t    i_op3,
  input  ridx_t    i_rd,
  input  logic     i_rd_wen,
  input  logic     i_skip_cmt,
  input  logic     i_mtime_overflow,
  output logic     o_valid,
  input  logic     i_ready,
  output xlen_t    o_pc,
  output inst_t    o_inst,
  output ridx_t    o_rd,
  output logic     o_rd_wen,
  output xlen_t    o_rd_wdata,
  output logic     o_jmp,
  output xlen_t    o_jmp_addr,
  output intr_no_t o_intr_no,
  output logic     o_skip_cmt
);

  logic      alu_start;
  logic      trap_start;
  op_e       trap_kind;
  logic      commit;
  logic      irq_enabled;
  op_e       held_op;
  xlen_t     held_pc;
  inst_t     held_inst;
  xlen_t     held_op1;
  xlen_t     held_op2;
  xlen_t     held_op3;
  xlen_t     alu_rd_wdata;
  logic      alu_jmp;
  xlen_t     alu_jmp_addr;
  logic      trap_done;
  xlen_t     trap_jmp_addr;
  csr_addr_t csr_raddr;
  xlen_t     csr_rdata;
  logic      csr_wen;
  csr_addr_t csr_waddr;
  xlen_t     csr_wdata;
  logic      save_en;
  xlen_t     save_mepc;
  xlen_t     save_mcause;
  logic      set_mtip;
  logic      mret_en;
  xlen_t     mtvec;
  xlen_t     mepc;

  exe_stage_ctrl ctrl_i (
    .clk              (clk),
    .rst              (rst),
    .i_valid          (i_valid),
    .i_op             (i_op),
    .i_pc             (i_pc),
    .i_inst           (i_inst),
    .i_op1            (i_op1),
    .i_op2            (i_op2),
    .i_op3            (i_op3),
    .i_rd             (i_rd),
    .i_rd_wen         (i_rd_wen),
    .i_skip_cmt       (i_skip_cmt),
    .i_ready          (i_ready),
    .i_mtime_overflow (i_mtime_overflow),
    .i_irq_enabled    (irq_enabled),
    .i_alu_rd_wdata   (alu_rd_wdata),
    .i_alu_jmp        (alu_jmp),
    .i_alu_jmp_addr   (alu_jmp_addr),
    .i_trap_done      (trap_done),
    .i_trap_jmp_addr  (trap_jmp_addr),
    .o_ready          (o_ready),
    .o_valid          (o_valid),
    .o_pc             (o_pc),
    .o_inst           (o_inst),
    .o_rd             (o_rd),
    .o_rd_wen         (o_rd_wen),
    .o_rd_wdata       (o_rd_wdata),
    .o_jmp            (o_jmp),
    .o_jmp_addr       (o_jmp_addr),
    .o_intr_no        (o_intr_no),
    .o_skip_cmt       (o_skip_cmt),
    .o_alu_start      (alu_start),
    .o_trap_start     (trap_start),
    .o_trap_kind      (trap_kind),
    .o_commit         (commit),
    .o_held_op        (held_op),
    .o_held_pc        (held_pc),
    .o_held_inst      (held_inst),
    .o_held_op1       (held_op1),
    .o_held_op2       (held_op2),
    .o_held_op3       (held_op3)
  );

  int_csr_unit int_i (
    .clk         (clk),
    .rst         (rst),
    .i_start     (alu_start),
    .i_op        (held_op),
    .i_pc        (held_pc),
    .i_op1       (held_op1),
    .i_op2       (held_op2),
    .i_op3       (held_op3),
    .i_inst      (held_inst),
    .i_csr_rdata (csr_rdata),
    .i_commit    (commit),
    .o_csr_raddr (csr_raddr),
    .o_csr_wen   (csr_wen),
    .o_csr_waddr (csr_waddr),
    .o_csr_wdata (csr_wdata),
    .o_rd_wdata  (alu_rd_wdata),
    .o_jmp       (alu_jmp),
    .o_jmp_addr  (alu_jmp_addr)
  );

  trap_unit trap_i (
    .clk           (clk),
    .rst           (rst),
    .i_start       (trap_start),
    .i_kind        (trap_kind),
    .i_pc          (held_pc),
    .i_mtvec       (mtvec),
    .i_mepc        (mepc),
    .o_save_en     (save_en),
    .o_save_mepc   (save_mepc),
    .o_save_mcause (save_mcause),
    .o_set_mtip    (set_mtip),
    .o_mret_en     (mret_en),
    .o_done        (trap_done),
    .o_jmp_addr    (trap_jmp_addr)
  );

  mcsr_file csr_i (
    .clk           (clk),
    .rst           (rst),
    .i_raddr       (csr_raddr),
    .i_wen         (csr_wen),
    .i_waddr       (csr_waddr),
    .i_wdata       (csr_wdata),
    .i_save_en     (save_en),
    .i_save_mepc   (save_mepc),
    .i_save_mcause (save_mcause),
    .i_set_mtip    (set_mtip),
    .i_mret_en     (mret_en),
    .o_rdata       (csr_rdata),
    .o_mtvec       (mtvec),
    .o_mepc        (mepc),
    .o_irq_enabled (irq_enabled)
  );

endmodule

// ==== verilog/int_csr_unit.sv ====
/* Integer and CSR execution unit */
`timescale 1ns/1ps

module int_csr_unit import exe_data_pkg::*, exe_op_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_start,
  input  op_e       i_op,
  input  xlen_t     i_pc,
  input  xlen_t     i_op1,
  input  xlen_t     i_op2,
  input  xlen_t     i_op3,
  input  inst_t     i_inst,
  input  xlen_t     i_csr_rdata,
  input  logic      i_commit,
  output csr_addr_t o_csr_raddr,
  output logic      o_csr_wen,
  output csr_addr_t o_csr_waddr,
  output xlen_t     o_csr_wdata,
  output xlen_t     o_rd_wdata,
  output logic      o_jmp,
  output xlen_t     o_jmp_addr
);

  xlen_t rd_d;
  xlen_t csr_d;
  logic  jmp_d;
  logic  csr_pend_d;
  logic  csr_pend_q;

  assign o_csr_raddr = i_inst[31:20];

  always_comb begin
    rd_d       = '0;
    csr_d      = '0;
    jmp_d      = 1'b0;
    csr_pend_d = 1'b0;
    case (i_op)
      op_add: rd_d = i_op1 + i_op2;
      op_sub: rd_d = i_op1 - i_op2;
      op_and: rd_d = i_op1 & i_op2;
      op_or:  rd_d = i_op1 | i_op2;
      op_xor: rd_d = i_op1 ^ i_op2;
      op_sll: rd_d = i_op1 << i_op2[5:0];
      op_srl: rd_d = i_op1 >> i_op2[5:0];
      op_slt: rd_d = {63'b0, $signed(i_op1) < $signed(i_op2)};
      op_beq: jmp_d = (i_op1 == i_op2);
      op_bne: jmp_d = (i_op1 != i_op2);
      op_jalr: begin
        rd_d  = i_pc + 64'd4;
        jmp_d = 1'b1;
      end
      op_csrrw: begin
        rd_d       = i_csr_rdata;
        csr_d      = i_op1;
        csr_pend_d = 1'b1;
      end
      op_csrrs: begin
        rd_d       = i_csr_rdata;
        csr_d      = i_csr_rdata | i_op1;
        csr_pend_d = 1'b1;
      end
      default: rd_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_jmp      <= 1'b0;
      csr_pend_q <= 1'b0;
    end else if (i_start) begin
      o_jmp      <= jmp_d;
      csr_pend_q <= csr_pend_d;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      o_rd_wdata  <= rd_d;
      o_csr_wdata <= csr_d;
      o_csr_waddr <= i_inst[31:20];
      // jalr target has bit 0 cleared
      o_jmp_addr  <= (i_op == op_jalr) ? ((i_op1 + i_op2) & ~64'd1) : (i_pc + i_op3);
    end
  end

  // CSR write lands on the output handshake
  assign o_csr_wen = csr_pend_q && i_commit;

endmodule

// ==== verilog/mcsr_file.sv ====
/* Machine CSR file */
`timescale 1ns/1ps
`include "exe_defines.svh"

module mcsr_file import exe_data_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  csr_addr_t i_raddr,
  input  logic      i_wen,
  input  csr_addr_t i_waddr,
  input  xlen_t     i_wdata,
  input  logic      i_save_en,
  input  xlen_t     i_save_mepc,
  input  xlen_t     i_save_mcause,
  input  logic      i_set_mtip,
  input  logic      i_mret_en,
  output xlen_t     o_rdata,
  output xlen_t     o_mtvec,
  output xlen_t     o_mepc,
  output logic      o_irq_enabled
);

  xlen_t mstatus;
  xlen_t mie;
  xlen_t mcause;
  xlen_t mip;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mie     <= '0;
      o_mtvec <= '0;
      o_mepc  <= '0;
      mcause  <= '0;
      mip     <= '0;
    end else if (i_save_en) begin
      o_mepc     <= i_save_mepc;
      mcause     <= i_save_mcause;
      // stack MIE into MPIE
      mstatus[7] <= mstatus[3];
      mstatus[3] <= 1'b0;
      if (i_set_mtip) mip <= `MIP_MTIP;
    end else if (i_mret_en) begin
      mstatus[3] <= mstatus[7];
    end else if (i_wen) begin
      case (i_waddr)
        `CSR_MSTATUS: mstatus <= i_wdata;
        `CSR_MIE:     mie     <= i_wdata;
        `CSR_MTVEC:   o_mtvec <= i_wdata;
        `CSR_MEPC:    o_mepc  <= i_wdata;
        `CSR_MCAUSE:  mcause  <= i_wdata;
        `CSR_MIP:     mip     <= i_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      `CSR_MSTATUS: o_rdata = mstatus;
      `CSR_MIE:     o_rdata = mie;
      `CSR_MTVEC:   o_rdata = o_mtvec;
      `CSR_MEPC:    o_rdata = o_mepc;
      `CSR_MCAUSE:  o_rdata = mcause;
      `CSR_MIP:     o_rdata = mip;
      default:      o_rdata = '0;
    endcase
  end

  // mstatus.MIE and mie.MTIE
  assign o_irq_enabled = mstatus[3] && mie[7];

endmodule

// ==== verilog/trap_unit.sv ====
/* Trap entry and mret sequencer */
`timescale 1ns/1ps
`include "exe_defines.svh"

module trap_unit import exe_data_pkg::*, exe_op_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_start,
  input  op_e   i_kind,
  input  xlen_t i_pc,
  input  xlen_t i_mtvec,
  input  xlen_t i_mepc,
  output logic  o_save_en,
  output xlen_t o_save_mepc,
  output xlen_t o_save_mcause,
  output logic  o_set_mtip,
  output logic  o_mret_en,
  output logic  o_done,
  output xlen_t o_jmp_addr
);

  trap_state_e state;
  op_e         kind_q;
  logic        is_mret;

  assign is_mret = (kind_q == op_mret);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= tr_idle;
      kind_q <= op_nop;
    end else begin
      case (state)
        tr_idle: begin
          if (i_start) begin
            state  <= tr_save;
            kind_q <= i_kind;
          end
        end
        tr_save:  state <= tr_cause;
        tr_cause: state <= tr_done;
        tr_done:  state <= tr_idle;
        default:  state <= tr_idle;
      endcase
    end
  end

  // op_nop marks the timer interrupt
  assign o_save_en     = (state == tr_save) && !is_mret;
  assign o_mret_en     = (state == tr_save) && is_mret;
  assign o_set_mtip    = (state == tr_save) && (kind_q == op_nop);
  assign o_save_mepc   = i_pc;
  assign o_save_mcause = (kind_q == op_nop) ? `CAUSE_MTIMER : `CAUSE_ECALL_M;

  // target settles once the CSR updates are in
  always_ff @(posedge clk) begin
    if (state == tr_cause) begin
      o_jmp_addr <= is_mret ? i_mepc : i_mtvec;
    end
  end

  assign o_done = (state == tr_cause);

endmodule
